// File: verilog/level1b_pkg.sv
`default_nettype none

package level1b_pkg;

  // ------------------------------------------------------------
  // Address map and sizing constants
  // ------------------------------------------------------------

  // Host register that selects the paged ROM, shadowed on every write
  localparam logic [15:0] bbc_paged_rom_sel  = 16'hFE30;
  // Slot assumed to hold BASIC, remapped together with the MOS
  localparam logic [3:0]  basic_rom_number   = 4'hF;
  // Only the low four ROM select bits are kept
  localparam int          pagereg_sz         = 4;
  // Holdoff depth after a host IO access, needed for clocks above 16MHz
  localparam int          io_access_delay_sz = 5;
  // Remapped ROM and RAM all land in FE0000-FFFFFF
  localparam logic [7:0]  remap_bank         = 8'hFE;
  // High host address byte used for a dummy read
  localparam logic [7:0]  dummy_adr_hi       = 8'h80;
  // Bits 7 and 3 of the map control register do not exist
  localparam logic [7:0]  map_ctrl_mask      = 8'h77;

  // ------------------------------------------------------------
  // Bus types
  // ------------------------------------------------------------

  // One CPU bus cycle with the latched bank byte
  typedef struct packed {
    logic [15:0] adr;
    logic [7:0]  bank;
    logic        vpa;
    logic        vda;
    logic        rnw;
  } cpu_cycle_t;

  // Bank byte seen in the address phase
  typedef struct packed {
    logic       himem;
    logic       ram_sel;
    logic [2:0] unused;
    logic [2:0] ram_adr;
  } bank_view_t;

  // Same byte written into the map control register
  typedef struct packed {
    logic       unused_7;
    logic       shadow_en;
    logic       rom_remap_en;
    logic       ram_remap_en;
    logic       unused_3;
    logic       hsclk_en;
    logic [1:0] cpuclk_div;
  } map_view_t;

  typedef union packed {
    bank_view_t bank;
    map_view_t  map;
  } bus_byte_u;

  // Per-cycle decode shared by the result-side blocks
  typedef struct packed {
    bus_byte_u eff_bank;
    logic      valid;
    logic      sync;
    logic      himem;
    logic      hisync;
    logic      io_access;
    logic      map_sel;
    logic      pagereg_sel;
    logic      write;
  } decode_t;

endpackage

`default_nettype wire

// File: verilog/bank_decode.sv
`timescale 1ns/100ps
`default_nettype none

module bank_decode (
  input  wire                                cpu_phi2_w,
  input  wire                                resetb,
  input  wire level1b_pkg::cpu_cycle_t       cyc,
  input  wire level1b_pkg::bus_byte_u        map,
  input  wire [level1b_pkg::pagereg_sz-1:0]  pagereg,
  output level1b_pkg::decode_t               dec
);

  logic                   valid;
  logic                   sync;
  logic                   rom_remap;
  logic                   ram_remap;
  logic                   vram_wr;
  logic                   mos_sync;
  level1b_pkg::bus_byte_u eff_bank;

  // VPA and VDA both low is an idle cycle, both high an opcode fetch
  assign valid = cyc.vpa | cyc.vda;
  assign sync  = cyc.vpa & cyc.vda;

  // ------------------------------------------------------------
  // Remapping
  // ------------------------------------------------------------

  always_comb begin
    rom_remap = 1'b0;
    if (map.map.rom_remap_en && !cyc.bank[7] && valid && cyc.adr[15]) begin
      if (cyc.adr[14]) begin
        // MOS at C000-FBFF only, the IO pages and vectors stay on the host
        rom_remap = !(&cyc.adr[13:10]);
      end else begin
        // Sideways area follows only when the BASIC slot is paged in
        rom_remap = (pagereg == level1b_pkg::basic_rom_number);
      end
    end
  end

  always_comb begin
    ram_remap = 1'b0;
    if (map.map.ram_remap_en && !cyc.bank[7] && !cyc.adr[15]) begin
      if (map.map.shadow_en) begin
        // 0-1FFF always moves, 2000-7FFF stays put for the MOS VDU code
        ram_remap = !(cyc.adr[14] | cyc.adr[13]) | !mos_sync;
      end else begin
        ram_remap = 1'b1;
      end
    end
  end

  // Bit 0 still comes from the CPU so both FE and FF can be reached
  assign eff_bank = (rom_remap || ram_remap) ?
                    {level1b_pkg::remap_bank[7:1], cyc.bank[0]} : cyc.bank;

  // Screen writes must reach host memory at host speed unless shadowed
  assign vram_wr = !cyc.rnw & !cyc.adr[15] & eff_bank.bank.himem & !map.map.shadow_en;

  // Set after an opcode fetch from C000-DFFF in bank 00 or FE, the MOS VDU area
  always_ff @(posedge cpu_phi2_w or negedge resetb) begin
    if (!resetb) begin
      mos_sync <= 1'b0;
    end else if (sync) begin
      mos_sync <= !eff_bank[0] && (cyc.adr[15:13] == 3'b110);
    end
  end

  always_comb begin
    dec.eff_bank    = eff_bank;
    dec.valid       = valid;
    dec.sync        = sync;
    dec.himem       = valid & eff_bank.bank.himem & !vram_wr;
    dec.hisync      = sync & eff_bank.bank.himem;
    // Host IO pages FC00-FFFF
    dec.io_access   = !cyc.bank[7] & (&cyc.adr[15:10]) & cyc.vda;
    dec.map_sel     = (cyc.bank[7:6] == 2'b10) && (cyc.adr[1:0] == 2'b11);
    dec.pagereg_sel = !cyc.bank[7] && (cyc.adr == level1b_pkg::bbc_paged_rom_sel);
    dec.write       = !cyc.rnw;
  end

  // The two register windows live in disjoint banks
  sel_exclusive: assert property (@(posedge cpu_phi2_w) disable iff (!resetb)
    !(dec.map_sel && dec.pagereg_sel))
    else $error("map and page register selected in the same cycle");

endmodule

`default_nettype wire

// File: verilog/map_registers.sv
`timescale 1ns/100ps
`default_nettype none

module map_registers (
  input  wire                                   cpu_phi2_w,
  input  wire                                   resetb,
  input  wire level1b_pkg::decode_t             dec,
  input  wire level1b_pkg::bus_byte_u           cpu_din,
  output level1b_pkg::bus_byte_u                map,
  output logic [level1b_pkg::pagereg_sz-1:0]    pagereg,
  output logic [7:0]                            rd_data,
  output logic                                  rd_en
);

  logic map_wr;
  logic pagereg_wr;

  // ------------------------------------------------------------
  // Register access strobes
  // ------------------------------------------------------------

  assign map_wr     = dec.valid & dec.write & dec.map_sel;
  assign pagereg_wr = dec.valid & dec.write & dec.pagereg_sel;

  // Only the map register reads back, the page register is write-only on the host
  assign rd_en   = dec.valid & !dec.write & dec.map_sel;
  // Divider bits are just stored and returned here
  assign rd_data = map;

  // ------------------------------------------------------------
  // Registers
  // ------------------------------------------------------------

  // New settings apply from the cycle after the write
  always_ff @(posedge cpu_phi2_w or negedge resetb) begin
    if (!resetb) begin
      map <= '0;
    end else if (map_wr) begin
      map <= cpu_din & level1b_pkg::map_ctrl_mask;
    end
  end

  // Copy of the host ROM select latch, the host still sees the write itself
  always_ff @(posedge cpu_phi2_w or negedge resetb) begin
    if (!resetb) begin
      pagereg <= '0;
    end else if (pagereg_wr) begin
      pagereg <= cpu_din[level1b_pkg::pagereg_sz-1:0];
    end
  end

  // Missing bits must read as zero
  map_unused_zero: assert property (@(posedge cpu_phi2_w) disable iff (!resetb)
    (map & ~level1b_pkg::map_ctrl_mask) == 8'h00)
    else $error("unimplemented map control bit set");

endmodule

`default_nettype wire

// File: verilog/clock_select.sv
`timescale 1ns/100ps
`default_nettype none

module clock_select (
  input  wire                        cpu_phi2_w,
  input  wire                        resetb,
  input  wire level1b_pkg::decode_t  dec,
  input  wire                        hsclk_en,
  output logic                       hs_sel
);

  logic [level1b_pkg::io_access_delay_sz-1:0] io_pipe;
  logic                                       hs_sel_d;

  // ------------------------------------------------------------
  // IO holdoff
  // ------------------------------------------------------------

  // Keeps timed host IO sequences at host speed for a few cycles
  always_ff @(posedge cpu_phi2_w or negedge resetb) begin
    if (!resetb) begin
      io_pipe <= '0;
    end else begin
      io_pipe <= (io_pipe >> 1) | {level1b_pkg::io_access_delay_sz{dec.io_access}};
    end
  end

  // ------------------------------------------------------------
  // Fast clock request
  // ------------------------------------------------------------

  // Switch up only on an opcode fetch from high memory
  // Data accesses and idle cycles can only keep the fast clock
  always_comb begin
    hs_sel_d = hsclk_en & ((dec.hisync & !io_pipe[0]) |
                           (dec.himem & hs_sel) |
                           (!dec.valid & hs_sel));
  end

  always_ff @(posedge cpu_phi2_w or negedge resetb) begin
    if (!resetb) begin
      hs_sel <= 1'b0;
    end else begin
      hs_sel <= hs_sel_d;
    end
  end

  // After a host IO access the fast clock stays off through the holdoff
  io_holdoff: assert property (@(posedge cpu_phi2_w) disable iff (!resetb)
    dec.io_access |=> !hs_sel [*5])
    else $error("fast clock selected inside IO holdoff");

endmodule

`default_nettype wire

// File: verilog/bus_steer.sv
`timescale 1ns/100ps
`default_nettype none

module bus_steer (
  input  wire level1b_pkg::decode_t     dec,
  input  wire                           hs_sel,
  input  wire level1b_pkg::cpu_cycle_t  cyc,
  input  wire [7:0]                     rd_data,
  input  wire                           rd_en,
  input  wire [7:0]                     bbc_din,
  output logic                          ram_ceb,
  output logic                          ram_web,
  output logic [2:0]                    ram_adr,
  output logic [7:0]                    bbc_adr,
  output logic                          bbc_rnw,
  output logic [7:0]                    cpu_dout,
  output logic                          cpu_doe
);

  logic dummy_access;
  logic host_rd;

  // ------------------------------------------------------------
  // On-board RAM
  // ------------------------------------------------------------

  // Banks with bit 6 set are RAM, bits 2 to 0 select one of eight 64K banks
  assign ram_ceb = !(dec.valid & dec.eff_bank.bank.ram_sel);
  assign ram_web = !(dec.valid & dec.eff_bank.bank.ram_sel & dec.write);
  assign ram_adr = dec.eff_bank.bank.ram_adr;

  // ------------------------------------------------------------
  // Host bus
  // ------------------------------------------------------------

  // The host sees a harmless read of ROM space while the CPU works elsewhere
  // or while it runs off the fast clock
  assign dummy_access = dec.himem | hs_sel;
  assign bbc_adr      = dummy_access ? level1b_pkg::dummy_adr_hi : cyc.adr[15:8];
  assign bbc_rnw      = cyc.rnw | dummy_access;

  // Real host read, the bank left in low memory after remapping
  assign host_rd = dec.valid & !dec.write & !dec.eff_bank.bank.himem;

  // Register reads win over the host data
  assign cpu_dout = rd_en ? rd_data : bbc_din;
  assign cpu_doe  = rd_en | host_rd;

  // Write enable is only ever given to a selected RAM
  web_needs_ceb: assert final (ram_web || !ram_ceb)
    else $error("RAM write strobe without chip enable");

endmodule

`default_nettype wire

// File: verilog/level1b_top.sv
`timescale 1ns/100ps
`default_nettype none

module level1b_top (
  input  wire                           cpu_phi2_w,
  input  wire                           resetb,
  input  wire level1b_pkg::cpu_cycle_t  cyc,
  input  wire [7:0]                     cpu_din,
  input  wire [7:0]                     bbc_din,
  output logic                          ram_ceb,
  output logic                          ram_web,
  output logic [2:0]                    ram_adr,
  output logic [7:0]                    bbc_adr,
  output logic                          bbc_rnw,
  output logic [7:0]                    cpu_dout,
  output logic                          cpu_doe,
  output logic                          hs_sel
);

  level1b_pkg::decode_t                 dec;
  level1b_pkg::bus_byte_u               map;
  logic [level1b_pkg::pagereg_sz-1:0]   pagereg;
  logic [7:0]                           rd_data;
  logic                                 rd_en;

  // ------------------------------------------------------------
  // Decode
  // ------------------------------------------------------------

  bank_decode u_bank_decode (
    .cpu_phi2_w (cpu_phi2_w),
    .resetb     (resetb),
    .cyc        (cyc),
    .map        (map),
    .pagereg    (pagereg),
    .dec        (dec)
  );

  // Map control and paged-ROM copy
  map_registers u_map_registers (
    .cpu_phi2_w (cpu_phi2_w),
    .resetb     (resetb),
    .dec        (dec),
    .cpu_din    (cpu_din),
    .map        (map),
    .pagereg    (pagereg),
    .rd_data    (rd_data),
    .rd_en      (rd_en)
  );

  // ------------------------------------------------------------
  // Result side
  // ------------------------------------------------------------

  clock_select u_clock_select (
    .cpu_phi2_w (cpu_phi2_w),
    .resetb     (resetb),
    .dec        (dec),
    .hsclk_en   (map.map.hsclk_en),
    .hs_sel     (hs_sel)
  );

  bus_steer u_bus_steer (
    .dec      (dec),
    .hs_sel   (hs_sel),
    .cyc      (cyc),
    .rd_data  (rd_data),
    .rd_en    (rd_en),
    .bbc_din  (bbc_din),
    .ram_ceb  (ram_ceb),
    .ram_web  (ram_web),
    .ram_adr  (ram_adr),
    .bbc_adr  (bbc_adr),
    .bbc_rnw  (bbc_rnw),
    .cpu_dout (cpu_dout),
    .cpu_doe  (cpu_doe)
  );

endmodule

`default_nettype wire

// File: verification/tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
  output logic cpu_phi2_w,
  output logic resetb
);

  // One CPU bus cycle every 10 ns
  initial begin
    cpu_phi2_w = 1'b0;
    forever begin
      #5 cpu_phi2_w = ~cpu_phi2_w;
    end
  end

  // Reset is held over ten rising edges and released just after the last one
  initial begin
    resetb = 1'b0;
    repeat (10) @(posedge cpu_phi2_w);
    #1 resetb = 1'b1;
  end

endmodule

`default_nettype wire

// File: verification/tb_level1b.sv
`timescale 1ns/100ps
`default_nettype none

module tb_level1b;

  logic                    cpu_phi2_w;
  logic                    resetb;
  level1b_pkg::cpu_cycle_t cyc;
  logic [7:0]              cpu_din;
  logic [7:0]              bbc_din;
  logic                    ram_ceb;
  logic                    ram_web;
  logic [2:0]              ram_adr;
  logic [7:0]              bbc_adr;
  logic                    bbc_rnw;
  logic [7:0]              cpu_dout;
  logic                    cpu_doe;
  logic                    hs_sel;

  // Reference model state, mirrors the registers of the card
  logic [7:0]  model_map;
  logic [3:0]  model_pagereg;
  logic        model_mos_sync;
  logic [4:0]  model_io_pipe;
  logic        model_hs_sel;
  int          error_count = 0;
  int          cycle_count = 0;
  logic [31:0] rnd;
  logic [31:0] rnd2;
  logic [7:0]  value;

  tb_clock_gen u_clock_gen (
    .cpu_phi2_w (cpu_phi2_w),
    .resetb     (resetb)
  );

  level1b_top i_level1b_top (
    .cpu_phi2_w (cpu_phi2_w),
    .resetb     (resetb),
    .cyc        (cyc),
    .cpu_din    (cpu_din),
    .bbc_din    (bbc_din),
    .ram_ceb    (ram_ceb),
    .ram_web    (ram_web),
    .ram_adr    (ram_adr),
    .bbc_adr    (bbc_adr),
    .bbc_rnw    (bbc_rnw),
    .cpu_dout   (cpu_dout),
    .cpu_doe    (cpu_doe),
    .hs_sel     (hs_sel)
  );

  // ------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------

  task automatic check_value(input string name, input logic [15:0] expected,
                             input logic [15:0] actual);
    if (expected !== actual) begin
      error_count++;
      $display("Error %s: expected %0h, actual %0h at %0t", name, expected, actual, $time);
    end
  endtask

  // Uniform address between two bounds, both included
  function automatic logic [15:0] rand_range(input int lo, input int hi);
    int result;
    result = lo + ($urandom % (hi - lo + 1));
    return result[15:0];
  endfunction

  // Drives one bus cycle, checks every output mid-cycle and steps the model
  task automatic run_cycle(input string name, input logic [15:0] adr, input logic [7:0] bank,
                           input logic vpa, input logic vda, input logic rnw,
                           input logic [7:0] din);
    logic       valid;
    logic       sync;
    logic       rom_remap;
    logic       ram_remap;
    logic [7:0] eff;
    logic       vram_wr;
    logic       himem;
    logic       hisync;
    logic       io_access;
    logic       map_sel;
    logic       pagereg_sel;
    logic       reg_rd;
    logic       doe;
    logic       dummy;
    logic       hs_next;
    @(posedge cpu_phi2_w);
    #1;
    cyc.adr  = adr;
    cyc.bank = bank;
    cyc.vpa  = vpa;
    cyc.vda  = vda;
    cyc.rnw  = rnw;
    cpu_din  = din;
    bbc_din  = $urandom;
    #4;
    valid = vpa | vda;
    sync  = vpa & vda;
    // MOS at C000-FBFF, sideways area only with the BASIC slot paged in
    rom_remap = 1'b0;
    if (model_map[5] && !bank[7] && valid && adr >= 16'h8000) begin
      if (adr >= 16'hC000) begin
        rom_remap = (adr < 16'hFC00);
      end else begin
        rom_remap = (model_pagereg == 4'hF);
      end
    end
    ram_remap = 1'b0;
    if (model_map[4] && !bank[7] && adr < 16'h8000) begin
      if (model_map[6] && adr >= 16'h2000) begin
        ram_remap = !model_mos_sync;
      end else begin
        ram_remap = 1'b1;
      end
    end
    eff         = (rom_remap || ram_remap) ? {7'h7F, bank[0]} : bank;
    vram_wr     = !rnw && adr < 16'h8000 && eff[7] && !model_map[6];
    himem       = valid && eff[7] && !vram_wr;
    hisync      = sync && eff[7];
    io_access   = !bank[7] && adr >= 16'hFC00 && vda;
    map_sel     = (bank[7:6] == 2'b10) && (adr[1:0] == 2'b11);
    pagereg_sel = !bank[7] && adr == 16'hFE30;
    reg_rd      = valid && rnw && map_sel;
    doe         = reg_rd || (valid && rnw && !eff[7]);
    dummy       = himem || model_hs_sel;
    check_value({name, " ram_ceb"}, !(valid && eff[6]), ram_ceb);
    check_value({name, " ram_web"}, !(valid && eff[6] && !rnw), ram_web);
    check_value({name, " ram_adr"}, eff[2:0], ram_adr);
    check_value({name, " bbc_adr"}, dummy ? 8'h80 : adr[15:8], bbc_adr);
    check_value({name, " bbc_rnw"}, rnw || dummy, bbc_rnw);
    check_value({name, " cpu_doe"}, doe, cpu_doe);
    if (doe) begin
      check_value({name, " cpu_dout"}, reg_rd ? model_map : bbc_din, cpu_dout);
    end
    check_value({name, " hs_sel"}, model_hs_sel, hs_sel);
    // Next state, every term uses the values from before the closing edge
    hs_next = model_map[2] && ((hisync && !model_io_pipe[0]) ||
                               (himem && model_hs_sel) || (!valid && model_hs_sel));
    model_io_pipe = io_access ? 5'b11111 : (model_io_pipe >> 1);
    model_hs_sel  = hs_next;
    if (sync) begin
      model_mos_sync = !eff[0] && adr >= 16'hC000 && adr < 16'hE000;
    end
    if (valid && !rnw && map_sel) begin
      model_map = din & 8'h77;
    end
    if (valid && !rnw && pagereg_sel) begin
      model_pagereg = din[3:0];
    end
  endtask

  // ------------------------------------------------------------
  // Timeout
  // ------------------------------------------------------------

  // The directed and random sequences need under 900 cycles
  always @(posedge cpu_phi2_w) begin
    cycle_count++;
    if (cycle_count >= 2000) begin
      $display("Run timed out after %0d cycles with %0d errors", cycle_count, error_count);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // ------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------

  initial begin
    void'($urandom(84));
    cyc            = '0;
    cyc.rnw        = 1'b1;
    cpu_din        = 8'h00;
    bbc_din        = 8'h00;
    model_map      = 8'h00;
    model_pagereg  = 4'h0;
    model_mos_sync = 1'b0;
    model_io_pipe  = 5'b00000;
    model_hs_sel   = 1'b0;
    repeat (5) @(negedge cpu_phi2_w);
    check_value("reset hs_sel", 16'h0, hs_sel);
    check_value("reset ram_ceb", 16'h1, ram_ceb);
    check_value("reset cpu_doe", 16'h0, cpu_doe);
    wait (resetb === 1'b1);

    // Map register writes read back masked
    repeat (16) begin
      rnd   = $urandom;
      value = rnd[31:24];
      run_cycle("map_write", {rnd[13:0], 2'b11}, {2'b10, rnd[21:16]}, 1'b0, 1'b1, 1'b0, value);
      run_cycle("map_read", {rnd[13:0], 2'b11}, {2'b10, rnd[21:16]}, 1'b0, 1'b1, 1'b1, 8'h00);
      check_value("map_readback", value & 8'h77, cpu_dout);
      check_value("map_readback doe", 16'h1, cpu_doe);
    end

    // ROM remap with the BASIC slot paged in
    run_cycle("rom_pagereg", 16'hFE30, 8'h00, 1'b0, 1'b1, 1'b0, 8'h0F);
    run_cycle("rom_map", 16'h0003, 8'h80, 1'b0, 1'b1, 1'b0, 8'h20);
    repeat (12) begin
      rnd = $urandom;
      run_cycle("rom_mos", rand_range(16'hC000, 16'hFBFF), {7'h00, rnd[0]},
                rnd[1], 1'b1, 1'b1, 8'h00);
      check_value("rom_mos ram_ceb", 16'h0, ram_ceb);
      run_cycle("rom_basic", rand_range(16'h8000, 16'hBFFF), {7'h00, rnd[2]},
                rnd[3], 1'b1, 1'b1, 8'h00);
      check_value("rom_basic ram_ceb", 16'h0, ram_ceb);
    end
    // Another slot and the IO pages stay on the host
    rnd = $urandom;
    run_cycle("rom_pagereg_other", 16'hFE30, 8'h00, 1'b0, 1'b1, 1'b0, {5'h00, rnd[2:0]});
    repeat (8) begin
      run_cycle("rom_other", rand_range(16'h8000, 16'hBFFF), 8'h00, 1'b0, 1'b1, 1'b1, 8'h00);
      check_value("rom_other ram_ceb", 16'h1, ram_ceb);
      run_cycle("rom_io", rand_range(16'hFC00, 16'hFFFF), 8'h00, 1'b0, 1'b1, 1'b1, 8'h00);
      check_value("rom_io ram_ceb", 16'h1, ram_ceb);
    end

    // RAM remap with shadowing, following the last opcode fetch
    run_cycle("shadow_map", 16'h0003, 8'h80, 1'b0, 1'b1, 1'b0, 8'h50);
    repeat (12) begin
      rnd = $urandom;
      run_cycle("shadow_mos_fetch", rand_range(16'hC000, 16'hDFFF), 8'h00,
                1'b1, 1'b1, 1'b1, 8'h00);
      run_cycle("shadow_kept", rand_range(16'h2000, 16'h7FFF), 8'h00, 1'b0, 1'b1, rnd[0], rnd[15:8]);
      check_value("shadow_kept ram_ceb", 16'h1, ram_ceb);
      run_cycle("shadow_low", rand_range(16'h0000, 16'h1FFF), 8'h00, 1'b0, 1'b1, rnd[1], rnd[23:16]);
      check_value("shadow_low ram_ceb", 16'h0, ram_ceb);
      run_cycle("shadow_user_fetch", rand_range(16'h8000, 16'hBFFF), 8'h00,
                1'b1, 1'b1, 1'b1, 8'h00);
      run_cycle("shadow_moved", rand_range(16'h2000, 16'h7FFF), 8'h00, 1'b0, 1'b1, rnd[2], rnd[31:24]);
      check_value("shadow_moved ram_ceb", 16'h0, ram_ceb);
    end

    // High memory gives a dummy host read, low memory reads the host
    run_cycle("dummy_map", 16'h0003, 8'h80, 1'b0, 1'b1, 1'b0, 8'h00);
    repeat (12) begin
      rnd  = $urandom;
      rnd2 = $urandom;
      // Upper half only, a write below 8000 would be a screen write to the host
      run_cycle("dummy_high", {1'b1, rnd[14:0]}, {2'b11, rnd[21:16]},
                rnd[22], 1'b1, rnd[23], rnd[31:24]);
      check_value("dummy_high bbc_adr", 16'h80, bbc_adr);
      check_value("dummy_high bbc_rnw", 16'h1, bbc_rnw);
      // Kept out of the IO pages so no holdoff carries into the clock sequence
      run_cycle("dummy_low", rand_range(16'h0000, 16'hFBFF), {1'b0, rnd2[22:16]},
                1'b0, 1'b1, 1'b1, 8'h00);
      check_value("dummy_low cpu_dout", bbc_din, cpu_dout);
    end

    // Fast clock after a high fetch, held off after host IO
    run_cycle("clk_map", 16'h0003, 8'h80, 1'b0, 1'b1, 1'b0, 8'h04);
    repeat (6) begin
      rnd = $urandom;
      run_cycle("clk_fetch", rnd[15:0], {2'b11, rnd[21:16]}, 1'b1, 1'b1, 1'b1, 8'h00);
      run_cycle("clk_io", rand_range(16'hFC00, 16'hFFFF), 8'h00, 1'b0, 1'b1, 1'b1, 8'h00);
      check_value("clk_fast", 16'h1, hs_sel);
      repeat (6) begin
        rnd = $urandom;
        run_cycle("clk_holdoff", rnd[15:0], {2'b11, rnd[21:16]}, 1'b1, 1'b1, 1'b1, 8'h00);
        check_value("clk_holdoff hs_sel", 16'h0, hs_sel);
      end
      run_cycle("clk_resume", rnd[15:0], {2'b11, rnd[21:16]}, 1'b1, 1'b1, 1'b1, 8'h00);
      check_value("clk_resume hs_sel", 16'h1, hs_sel);
    end

    // Unconstrained cycles against the model
    repeat (600) begin
      rnd  = $urandom;
      rnd2 = $urandom;
      run_cycle("random", rnd[15:0], rnd[23:16], rnd[24], rnd[25], rnd[26], rnd2[7:0]);
    end

    $display("Run finished after %0d cycles with %0d errors", cycle_count, error_count);
    if (error_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
verilog/level1b_pkg.sv
verilog/bank_decode.sv
verilog/map_registers.sv
verilog/clock_select.sv
verilog/bus_steer.sv
verilog/level1b_top.sv
verification/tb_clock_gen.sv
verification/tb_level1b.sv

// File: Bender.yml
package:
  name: level1b

sources:
  - verilog/level1b_pkg.sv
  - verilog/bank_decode.sv
  - verilog/map_registers.sv
  - verilog/clock_select.sv
  - verilog/bus_steer.sv
  - verilog/level1b_top.sv
  - target: simulation
    files:
      - verification/tb_clock_gen.sv
      - verification/tb_level1b.sv
